//--- hdl/ecc_pkg.sv
// SECDED (39,32) code parameters and status counter width
// hsiao check-bit parity masks, syndrome and error class types
package ecc_pkg;

  // data bits covered by one codeword
  localparam int unsigned DATA_BITS   = 32;
  localparam int unsigned NB_ECC_BITS = 7;
  // codeword is check bits on top of the data word
  localparam int unsigned CW          = DATA_BITS + NB_ECC_BITS;

  // width of the correctable / uncorrectable event counters
  localparam int unsigned CNT_W = 16;

  typedef logic [NB_ECC_BITS-1:0] ecc_t;
  typedef logic [CW-1:0]          codeword_t;
  typedef logic [NB_ECC_BITS-1:0] syndrome_t;
  // bit 0 single error corrected, bit 1 double error detected
  typedef logic [1:0]             ecc_err_t;

  // hsiao masks, one per check bit
  // data bit i has a weight-3 column built from bit i of each mask,
  // all 32 columns distinct, so a single data error maps to one column
  // and any double error leaves an even, nonzero syndrome
  localparam logic [DATA_BITS-1:0] ECC_MASK_0 = 32'h0000_7FFF;
  localparam logic [DATA_BITS-1:0] ECC_MASK_1 = 32'h01FF_801F;
  localparam logic [DATA_BITS-1:0] ECC_MASK_2 = 32'h7E07_81E1;
  localparam logic [DATA_BITS-1:0] ECC_MASK_3 = 32'h8E38_8E22;
  localparam logic [DATA_BITS-1:0] ECC_MASK_4 = 32'hB2C9_3244;
  localparam logic [DATA_BITS-1:0] ECC_MASK_5 = 32'hD552_5488;
  localparam logic [DATA_BITS-1:0] ECC_MASK_6 = 32'h69A4_6910;

endpackage

//--- hdl/hci_mem_pkg.sv
// bus-side widths of the hci memory port
// vector types for address, data, byte enable and user fields
package hci_mem_pkg;

  // data word follows the secded code width
  localparam int unsigned DW = ecc_pkg::DATA_BITS;
  // word address, one bank of 256 words
  localparam int unsigned AW = 8;
  // requester user field
  localparam int unsigned UW = 4;
  // memory-side user field carries the check bits above the user bits
  localparam int unsigned EUW = UW + ecc_pkg::NB_ECC_BITS;

  // bank geometry
  localparam int unsigned BANK_WORDS = 1 << AW;
  localparam int unsigned NB_BYTES   = DW / 8;

  typedef logic [DW-1:0]       data_t;
  typedef logic [AW-1:0]       addr_t;
  typedef logic [NB_BYTES-1:0] be_t;
  typedef logic [UW-1:0]       user_t;
  typedef logic [EUW-1:0]      ecc_user_t;

endpackage

//--- hdl/secded_39_32_enc.sv
// hsiao secded encoder, 32 data bits to a 39-bit codeword
// purely combinational
module secded_39_32_enc (
  input  hci_mem_pkg::data_t data_i,
  output ecc_pkg::codeword_t codeword_o
);

  // check bits, one parity per mask
  ecc_pkg::ecc_t check;

  always_comb begin
    // each check bit is the even parity of the data bits it covers
    check[0] = ^(data_i & ecc_pkg::ECC_MASK_0);
    check[1] = ^(data_i & ecc_pkg::ECC_MASK_1);
    check[2] = ^(data_i & ecc_pkg::ECC_MASK_2);
    check[3] = ^(data_i & ecc_pkg::ECC_MASK_3);
    check[4] = ^(data_i & ecc_pkg::ECC_MASK_4);
    check[5] = ^(data_i & ecc_pkg::ECC_MASK_5);
    check[6] = ^(data_i & ecc_pkg::ECC_MASK_6);
  end

  // systematic code, data stays in the low bits
  // check bits go on top
  assign codeword_o = {check, data_i};

endmodule

//--- hdl/secded_39_32_dec.sv
// hsiao secded decoder for the 39-bit codeword
// corrects single errors, flags double errors, reports the syndrome
module secded_39_32_dec (
  input  ecc_pkg::codeword_t codeword_i,
  output hci_mem_pkg::data_t data_o,
  output ecc_pkg::syndrome_t syndrome_o,
  output ecc_pkg::ecc_err_t  err_o
);

  // received fields
  hci_mem_pkg::data_t data_raw;
  ecc_pkg::ecc_t      check_raw;
  // parity recomputed from the received data
  ecc_pkg::ecc_t      check_calc;
  // one bit per data position that the syndrome points at
  hci_mem_pkg::data_t flip;
  logic               single_err;
  logic               double_err;

  assign data_raw  = codeword_i[ecc_pkg::DATA_BITS-1:0];
  assign check_raw = codeword_i[ecc_pkg::CW-1:ecc_pkg::DATA_BITS];

  always_comb begin
    check_calc[0] = ^(data_raw & ecc_pkg::ECC_MASK_0);
    check_calc[1] = ^(data_raw & ecc_pkg::ECC_MASK_1);
    check_calc[2] = ^(data_raw & ecc_pkg::ECC_MASK_2);
    check_calc[3] = ^(data_raw & ecc_pkg::ECC_MASK_3);
    check_calc[4] = ^(data_raw & ecc_pkg::ECC_MASK_4);
    check_calc[5] = ^(data_raw & ecc_pkg::ECC_MASK_5);
    check_calc[6] = ^(data_raw & ecc_pkg::ECC_MASK_6);
  end

  // zero when the stored word is intact
  assign syndrome_o = check_calc ^ check_raw;

  // odd weight means one flipped bit, even nonzero weight means two
  assign single_err = ^syndrome_o;
  assign double_err = (syndrome_o != '0) && !single_err;

  // match the syndrome against every data column
  // a one-hot syndrome hits no column, so a check-bit error leaves data alone
  always_comb begin
    for (int i = 0; i < ecc_pkg::DATA_BITS; i++) begin
      flip[i] = single_err && (syndrome_o == {ecc_pkg::ECC_MASK_6[i],
                                              ecc_pkg::ECC_MASK_5[i],
                                              ecc_pkg::ECC_MASK_4[i],
                                              ecc_pkg::ECC_MASK_3[i],
                                              ecc_pkg::ECC_MASK_2[i],
                                              ecc_pkg::ECC_MASK_1[i],
                                              ecc_pkg::ECC_MASK_0[i]});
    end
  end

  assign data_o = data_raw ^ flip;
  assign err_o  = {double_err, single_err};

  // error class is a single code, never both flags
  // and an intact word never raises a flag
  always_comb begin
    assert (err_o != 2'b11)
      else $error("secded decoder flagged single and double error together");
    assert ((syndrome_o != '0) || (err_o == 2'b00))
      else $error("secded decoder flagged an error with a zero syndrome");
  end

endmodule

//--- hdl/hci_mem_ecc_enc.sv
// ecc stage between the requester and the memory bank
// appends check bits to writes in the upper user bits, corrects read data
module hci_mem_ecc_enc (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // requester side
  input  logic                   req_i,
  input  hci_mem_pkg::addr_t     add_i,
  input  logic                   wen_i,
  input  hci_mem_pkg::be_t       be_i,
  input  hci_mem_pkg::data_t     data_i,
  input  hci_mem_pkg::user_t     user_i,
  output logic                   gnt_o,
  output logic                   r_valid_o,
  output hci_mem_pkg::data_t     r_data_o,
  output hci_mem_pkg::user_t     r_user_o,
  // memory side
  output logic                   mem_req_o,
  output hci_mem_pkg::addr_t     mem_add_o,
  output logic                   mem_wen_o,
  output hci_mem_pkg::be_t       mem_be_o,
  output hci_mem_pkg::data_t     mem_data_o,
  output hci_mem_pkg::ecc_user_t mem_user_o,
  input  logic                   mem_gnt_i,
  input  logic                   mem_r_valid_i,
  input  hci_mem_pkg::data_t     mem_r_data_i,
  input  hci_mem_pkg::ecc_user_t mem_r_user_i,
  // decode status of the current read response
  output ecc_pkg::syndrome_t     syndrome_o,
  output ecc_pkg::ecc_err_t      err_o
);

  ecc_pkg::codeword_t wr_codeword;
  ecc_pkg::codeword_t rd_codeword;

  // handshake and control go straight through
  assign mem_req_o = req_i;
  assign gnt_o     = mem_gnt_i;
  assign mem_add_o = add_i;
  assign mem_wen_o = wen_i;
  assign mem_be_o  = be_i;
  assign r_valid_o = mem_r_valid_i;

  // check bits cover the full word, whatever be_i says
  secded_39_32_enc i_ecc_encode (
    .data_i     ( data_i      ),
    .codeword_o ( wr_codeword )
  );

  // low half of the codeword is the data word itself
  assign mem_data_o = wr_codeword[ecc_pkg::DATA_BITS-1:0];
  assign mem_user_o = {wr_codeword[ecc_pkg::CW-1:ecc_pkg::DATA_BITS], user_i};

  // rebuild the stored codeword from the response
  assign rd_codeword = {mem_r_user_i[hci_mem_pkg::EUW-1:hci_mem_pkg::UW], mem_r_data_i};

  secded_39_32_dec i_ecc_decode (
    .codeword_i ( rd_codeword ),
    .data_o     ( r_data_o    ),
    .syndrome_o ( syndrome_o  ),
    .err_o      ( err_o       )
  );

  // requester only sees its own user bits
  assign r_user_o = mem_r_user_i[hci_mem_pkg::UW-1:0];

  // a stalled request must keep its address until the bank grants it
  addr_held_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i && !gnt_o) |=> (req_i && $stable(add_i)))
    else $error("request address changed while waiting for grant");

endmodule

//--- hdl/hci_mem_bank.sv
// single-port sram bank with immediate grant and one-cycle read response
// stores data plus extended user bits, byte-masked writes
// error injection xors a mask into a stored codeword
module hci_mem_bank (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_i,
  input  hci_mem_pkg::addr_t     add_i,
  input  logic                   wen_i,
  input  hci_mem_pkg::be_t       be_i,
  input  hci_mem_pkg::data_t     data_i,
  input  hci_mem_pkg::ecc_user_t user_i,
  // bit-flip injection
  input  logic                   inj_req_i,
  input  hci_mem_pkg::addr_t     inj_add_i,
  input  ecc_pkg::codeword_t     inj_mask_i,
  output logic                   gnt_o,
  output logic                   r_valid_o,
  output hci_mem_pkg::data_t     r_data_o,
  output hci_mem_pkg::ecc_user_t r_user_o
);

  // storage, contents undefined until written
  hci_mem_pkg::data_t     data_mem [hci_mem_pkg::BANK_WORDS];
  hci_mem_pkg::ecc_user_t user_mem [hci_mem_pkg::BANK_WORDS];

  logic                   rd_acc;
  logic                   wr_acc;
  logic                   r_valid_q;
  hci_mem_pkg::data_t     r_data_q;
  hci_mem_pkg::ecc_user_t r_user_q;

  // injection owns the array for its cycle
  assign gnt_o  = !inj_req_i;
  assign rd_acc = req_i && gnt_o && wen_i;
  // wen low is a write
  assign wr_acc = req_i && gnt_o && !wen_i;

  always_ff @(posedge clk_i) begin
    if (inj_req_i) begin
      // data half of the mask hits the data word, upper half the check bits
      data_mem[inj_add_i] <= data_mem[inj_add_i] ^ inj_mask_i[ecc_pkg::DATA_BITS-1:0];
      user_mem[inj_add_i][hci_mem_pkg::EUW-1:hci_mem_pkg::UW] <=
        user_mem[inj_add_i][hci_mem_pkg::EUW-1:hci_mem_pkg::UW] ^
        inj_mask_i[ecc_pkg::CW-1:ecc_pkg::DATA_BITS];
    end else if (wr_acc) begin
      for (int b = 0; b < hci_mem_pkg::NB_BYTES; b++) begin
        if (be_i[b]) begin
          data_mem[add_i][8*b +: 8] <= data_i[8*b +: 8];
        end
      end
      // user and check bits always follow the whole new word
      user_mem[add_i] <= user_i;
    end
  end

  // response strobe
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_acc;
    end
  end

  // read payload, only loaded on an accepted read
  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      r_data_q <= data_mem[add_i];
      r_user_q <= user_mem[add_i];
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign r_user_o  = r_user_q;

  // every response belongs to a read granted one cycle earlier
  rvalid_after_read_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o |-> $past(req_i && gnt_o && wen_i))
    else $error("read response without an accepted read");

endmodule

//--- hdl/hci_mem_ecc_status.sv
// ecc status: saturating counters for corrected and uncorrectable reads
// keeps the last nonzero syndrome seen on a read response
module hci_mem_ecc_status (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      r_valid_i,
  input  ecc_pkg::syndrome_t        syndrome_i,
  input  ecc_pkg::ecc_err_t         err_i,
  output logic [ecc_pkg::CNT_W-1:0] corr_cnt_o,
  output logic [ecc_pkg::CNT_W-1:0] uncorr_cnt_o,
  output ecc_pkg::syndrome_t        last_syndrome_o
);

  logic [ecc_pkg::CNT_W-1:0] corr_cnt_q;
  logic [ecc_pkg::CNT_W-1:0] uncorr_cnt_q;
  ecc_pkg::syndrome_t        last_syn_q;

  // decode outputs only count while a response is on the bus
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      corr_cnt_q   <= '0;
      uncorr_cnt_q <= '0;
      last_syn_q   <= '0;
    end else if (r_valid_i) begin
      // stick at all ones instead of wrapping
      if (err_i[0] && (corr_cnt_q != '1)) begin
        corr_cnt_q <= corr_cnt_q + 1'b1;
      end
      if (err_i[1] && (uncorr_cnt_q != '1)) begin
        uncorr_cnt_q <= uncorr_cnt_q + 1'b1;
      end
      // clean reads leave the last syndrome in place
      if (syndrome_i != '0) begin
        last_syn_q <= syndrome_i;
      end
    end
  end

  assign corr_cnt_o      = corr_cnt_q;
  assign uncorr_cnt_o    = uncorr_cnt_q;
  assign last_syndrome_o = last_syn_q;

endmodule

//--- hdl/hci_mem_ecc_top.sv
// secded-protected memory path
// ecc stage, sram bank with error injection, and ecc status counters
module hci_mem_ecc_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // requester
  input  logic                      req_i,
  input  hci_mem_pkg::addr_t        add_i,
  input  logic                      wen_i,
  input  hci_mem_pkg::be_t          be_i,
  input  hci_mem_pkg::data_t        data_i,
  input  hci_mem_pkg::user_t        user_i,
  output logic                      gnt_o,
  output logic                      r_valid_o,
  output hci_mem_pkg::data_t        r_data_o,
  output hci_mem_pkg::user_t        r_user_o,
  output ecc_pkg::syndrome_t        syndrome_o,
  output ecc_pkg::ecc_err_t         err_o,
  // error injection into the bank
  input  logic                      inj_req_i,
  input  hci_mem_pkg::addr_t        inj_add_i,
  input  ecc_pkg::codeword_t        inj_mask_i,
  // status
  output logic [ecc_pkg::CNT_W-1:0] corr_cnt_o,
  output logic [ecc_pkg::CNT_W-1:0] uncorr_cnt_o,
  output ecc_pkg::syndrome_t        last_syndrome_o
);

  // ecc stage to bank
  logic                   mem_req;
  hci_mem_pkg::addr_t     mem_add;
  logic                   mem_wen;
  hci_mem_pkg::be_t       mem_be;
  hci_mem_pkg::data_t     mem_data;
  hci_mem_pkg::ecc_user_t mem_user;
  logic                   mem_gnt;
  logic                   mem_r_valid;
  hci_mem_pkg::data_t     mem_r_data;
  hci_mem_pkg::ecc_user_t mem_r_user;

  hci_mem_ecc_enc i_ecc_enc (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .req_i         ( req_i       ),
    .add_i         ( add_i       ),
    .wen_i         ( wen_i       ),
    .be_i          ( be_i        ),
    .data_i        ( data_i      ),
    .user_i        ( user_i      ),
    .gnt_o         ( gnt_o       ),
    .r_valid_o     ( r_valid_o   ),
    .r_data_o      ( r_data_o    ),
    .r_user_o      ( r_user_o    ),
    .mem_req_o     ( mem_req     ),
    .mem_add_o     ( mem_add     ),
    .mem_wen_o     ( mem_wen     ),
    .mem_be_o      ( mem_be      ),
    .mem_data_o    ( mem_data    ),
    .mem_user_o    ( mem_user    ),
    .mem_gnt_i     ( mem_gnt     ),
    .mem_r_valid_i ( mem_r_valid ),
    .mem_r_data_i  ( mem_r_data  ),
    .mem_r_user_i  ( mem_r_user  ),
    .syndrome_o    ( syndrome_o  ),
    .err_o         ( err_o       )
  );

  hci_mem_bank i_bank (
    .clk_i      ( clk_i       ),
    .rst_n_i    ( rst_n_i     ),
    .req_i      ( mem_req     ),
    .add_i      ( mem_add     ),
    .wen_i      ( mem_wen     ),
    .be_i       ( mem_be      ),
    .data_i     ( mem_data    ),
    .user_i     ( mem_user    ),
    .inj_req_i  ( inj_req_i   ),
    .inj_add_i  ( inj_add_i   ),
    .inj_mask_i ( inj_mask_i  ),
    .gnt_o      ( mem_gnt     ),
    .r_valid_o  ( mem_r_valid ),
    .r_data_o   ( mem_r_data  ),
    .r_user_o   ( mem_r_user  )
  );

  // status samples the decode of each response
  hci_mem_ecc_status i_status (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .r_valid_i       ( mem_r_valid     ),
    .syndrome_i      ( syndrome_o      ),
    .err_i           ( err_o           ),
    .corr_cnt_o      ( corr_cnt_o      ),
    .uncorr_cnt_o    ( uncorr_cnt_o    ),
    .last_syndrome_o ( last_syndrome_o )
  );

endmodule

//--- test/tb_hci_mem_ecc.sv
// testbench for the secded-protected memory path
// stimulus tasks, shadow memory reference model, response compare and watchdog
module tb_hci_mem_ecc;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 5;
  localparam int N_CLEAN    = 16;
  localparam int N_SINGLE   = 8;
  localparam int N_DOUBLE   = 6;
  localparam int N_B2B      = 8;
  // each error case is a write, an injection and a read
  // the stall case adds three more
  localparam int NUM_OPS       = 2*N_CLEAN + 3*N_SINGLE + 3*N_DOUBLE + 3 + 2*N_B2B;
  localparam int WATCHDOG_TIME = (NUM_OPS*20 + RST_CYCLES) * CLK_PERIOD;
  // wen high is a read
  localparam logic RD = 1'b1;
  localparam logic WR = 1'b0;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      req_i;
  hci_mem_pkg::addr_t        add_i;
  logic                      wen_i;
  hci_mem_pkg::be_t          be_i;
  hci_mem_pkg::data_t        data_i;
  hci_mem_pkg::user_t        user_i;
  logic                      gnt_o;
  logic                      r_valid_o;
  hci_mem_pkg::data_t        r_data_o;
  hci_mem_pkg::user_t        r_user_o;
  ecc_pkg::syndrome_t        syndrome_o;
  ecc_pkg::ecc_err_t         err_o;
  logic                      inj_req_i;
  hci_mem_pkg::addr_t        inj_add_i;
  ecc_pkg::codeword_t        inj_mask_i;
  logic [ecc_pkg::CNT_W-1:0] corr_cnt_o;
  logic [ecc_pkg::CNT_W-1:0] uncorr_cnt_o;
  ecc_pkg::syndrome_t        last_syndrome_o;

  integer seed = 32'hf633;
  int     cyc  = 0;
  int     err_data;
  int     err_user;
  int     err_class;
  int     err_cnt;
  int     err_other;

  // shadow of the bank plus the flips injected since the last write
  hci_mem_pkg::data_t shadow_data [hci_mem_pkg::BANK_WORDS];
  hci_mem_pkg::user_t shadow_user [hci_mem_pkg::BANK_WORDS];
  ecc_pkg::codeword_t inj_acc     [hci_mem_pkg::BANK_WORDS];

  // expected responses in issue order
  hci_mem_pkg::data_t exp_data_q [$];
  hci_mem_pkg::user_t exp_user_q [$];
  ecc_pkg::ecc_err_t  exp_err_q  [$];
  int                 exp_cyc_q  [$];
  logic [ecc_pkg::CNT_W-1:0] model_corr;
  logic [ecc_pkg::CNT_W-1:0] model_uncorr;

  hci_mem_ecc_top uut (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .req_i           ( req_i           ),
    .add_i           ( add_i           ),
    .wen_i           ( wen_i           ),
    .be_i            ( be_i            ),
    .data_i          ( data_i          ),
    .user_i          ( user_i          ),
    .gnt_o           ( gnt_o           ),
    .r_valid_o       ( r_valid_o       ),
    .r_data_o        ( r_data_o        ),
    .r_user_o        ( r_user_o        ),
    .syndrome_o      ( syndrome_o      ),
    .err_o           ( err_o           ),
    .inj_req_i       ( inj_req_i       ),
    .inj_add_i       ( inj_add_i       ),
    .inj_mask_i      ( inj_mask_i      ),
    .corr_cnt_o      ( corr_cnt_o      ),
    .uncorr_cnt_o    ( uncorr_cnt_o    ),
    .last_syndrome_o ( last_syndrome_o )
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%0t: %s", $time, msg);
    err_other++;
  endtask

  task automatic check_data(input string name, input hci_mem_pkg::data_t got,
                            input hci_mem_pkg::data_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
      err_data++;
    end
  endtask

  task automatic check_user(input string name, input hci_mem_pkg::user_t got,
                            input hci_mem_pkg::user_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
      err_user++;
    end
  endtask

  task automatic check_err(input string name, input ecc_pkg::ecc_err_t got,
                           input ecc_pkg::ecc_err_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s: got %b, expected %b", $time, name, got, exp);
      err_class++;
    end
  endtask

  task automatic check_cnt(input string name, input logic [ecc_pkg::CNT_W-1:0] got,
                           input logic [ecc_pkg::CNT_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t %s: got %0d, expected %0d", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // secded behavior by number of flipped codeword bits
  // one flip corrects back to the written word, two flips are only flagged
  function automatic ecc_pkg::ecc_err_t ref_read(input hci_mem_pkg::data_t word,
                                                 input int unsigned flips,
                                                 output hci_mem_pkg::data_t exp_data);
    exp_data = word;
    if (flips == 0) begin
      ref_read = 2'b00;
    end else if (flips == 1) begin
      ref_read = 2'b01;
    end else begin
      ref_read = 2'b10;
    end
  endfunction

  function automatic hci_mem_pkg::addr_t rand_addr();
    rand_addr = hci_mem_pkg::addr_t'($random(seed));
  endfunction

  function automatic hci_mem_pkg::data_t rand_data();
    rand_data = $random(seed);
  endfunction

  function automatic hci_mem_pkg::user_t rand_user();
    rand_user = hci_mem_pkg::user_t'($random(seed));
  endfunction

  // any codeword position in the data or check bits
  function automatic int unsigned rand_pos();
    rand_pos = $unsigned($random(seed)) % ecc_pkg::CW;
  endfunction

  // monitor of accepted requests builds the expected responses
  always @(posedge clk_i) begin : monitor
    hci_mem_pkg::data_t d;
    ecc_pkg::ecc_err_t  e;
    cyc = cyc + 1;
    if (rst_n_i) begin
      if (inj_req_i && gnt_o) begin
        report_failure("gnt_o high in an injection cycle");
      end
      if (req_i && gnt_o && wen_i) begin
        e = ref_read(shadow_data[add_i], $countones(inj_acc[add_i]), d);
        exp_data_q.push_back(d);
        exp_user_q.push_back(shadow_user[add_i]);
        exp_err_q.push_back(e);
        exp_cyc_q.push_back(cyc);
      end else if (req_i && gnt_o) begin
        shadow_data[add_i] = data_i;
        shadow_user[add_i] = user_i;
        inj_acc[add_i]     = '0;
      end
      // flips of the same bit cancel, so track the xor of all masks
      if (inj_req_i) begin
        inj_acc[inj_add_i] = inj_acc[inj_add_i] ^ inj_mask_i;
      end
    end
  end

  // compare each response with the oldest expected read
  always @(negedge clk_i) begin : compare
    hci_mem_pkg::data_t d;
    hci_mem_pkg::user_t u;
    ecc_pkg::ecc_err_t  e;
    int                 c;
    if (rst_n_i) begin
      if (r_valid_o) begin
        if (exp_cyc_q.size() == 0) begin
          report_failure("r_valid_o without an outstanding read");
        end else begin
          d = exp_data_q.pop_front();
          u = exp_user_q.pop_front();
          e = exp_err_q.pop_front();
          c = exp_cyc_q.pop_front();
          if (c != cyc) begin
            report_failure("r_valid_o not one cycle after its accepted read");
          end
          // data after a double error is not defined
          if (e != 2'b10) begin
            check_data("r_data_o", r_data_o, d);
          end
          check_user("r_user_o", r_user_o, u);
          check_err("err_o", err_o, e);
          if ((e == 2'b00) && (syndrome_o != '0)) begin
            report_failure("nonzero syndrome on a clean read");
          end
          if ((e != 2'b00) && (syndrome_o == '0)) begin
            report_failure("zero syndrome on a read with injected errors");
          end
          if (e[0]) begin
            model_corr = model_corr + 1'b1;
          end
          if (e[1]) begin
            model_uncorr = model_uncorr + 1'b1;
          end
        end
      end else if ((exp_cyc_q.size() != 0) && (exp_cyc_q[0] < cyc)) begin
        // a response one cycle late is still matched above
        report_failure("no r_valid_o for an accepted read");
        exp_data_q.delete();
        exp_user_q.delete();
        exp_err_q.delete();
        exp_cyc_q.delete();
      end
    end
  end

  // full-word request held until granted
  task automatic issue(input logic rd, input hci_mem_pkg::addr_t a,
                       input hci_mem_pkg::data_t d, input hci_mem_pkg::user_t u);
    @(negedge clk_i);
    req_i  = 1'b1;
    wen_i  = rd;
    add_i  = a;
    be_i   = '1;
    data_i = d;
    user_i = u;
    do @(posedge clk_i); while (!gnt_o);
  endtask

  task automatic go_idle();
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  task automatic inject(input hci_mem_pkg::addr_t a, input ecc_pkg::codeword_t m);
    @(negedge clk_i);
    req_i      = 1'b0;
    inj_req_i  = 1'b1;
    inj_add_i  = a;
    inj_mask_i = m;
    @(negedge clk_i);
    inj_req_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_cyc_q.size() != 0) @(negedge clk_i);
  endtask

  // write a word, flip nflips distinct codeword bits and read it back
  task automatic error_case(input int unsigned nflips);
    hci_mem_pkg::addr_t a;
    ecc_pkg::codeword_t m;
    a = rand_addr();
    m = '0;
    while ($countones(m) < nflips) begin
      m = m | (ecc_pkg::codeword_t'(1) << rand_pos());
    end
    issue(WR, a, rand_data(), rand_user());
    inject(a, m);
    issue(RD, a, '0, '0);
    go_idle();
  endtask

  // read held across an injection into a neighbouring word
  task automatic stall_read(input hci_mem_pkg::addr_t a);
    @(negedge clk_i);
    req_i      = 1'b1;
    wen_i      = RD;
    add_i      = a;
    inj_req_i  = 1'b1;
    inj_add_i  = a ^ hci_mem_pkg::addr_t'(1);
    inj_mask_i = ecc_pkg::codeword_t'(1) << rand_pos();
    @(posedge clk_i);
    @(negedge clk_i);
    inj_req_i = 1'b0;
    do @(posedge clk_i); while (!gnt_o);
    go_idle();
  endtask

  initial begin : main
    hci_mem_pkg::addr_t addrs [N_CLEAN];
    int                 total;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    req_i        = 1'b0;
    add_i        = '0;
    wen_i        = RD;
    be_i         = '1;
    data_i       = '0;
    user_i       = '0;
    inj_req_i    = 1'b0;
    inj_add_i    = '0;
    inj_mask_i   = '0;
    model_corr   = '0;
    model_uncorr = '0;
    repeat (RST_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;

    // clean path
    for (int i = 0; i < N_CLEAN; i++) begin
      addrs[i] = rand_addr();
      issue(WR, addrs[i], rand_data(), rand_user());
    end
    for (int i = 0; i < N_CLEAN; i++) begin
      issue(RD, addrs[i], '0, '0);
    end
    go_idle();
    drain();

    // single-bit correction, then double-bit detection
    repeat (N_SINGLE) error_case(1);
    repeat (N_DOUBLE) error_case(2);
    drain();

    // injection stall with a read waiting
    addrs[0] = rand_addr();
    issue(WR, addrs[0], rand_data(), rand_user());
    stall_read(addrs[0]);
    drain();

    // back-to-back reads
    for (int i = 0; i < N_B2B; i++) begin
      addrs[i] = rand_addr();
      issue(WR, addrs[i], rand_data(), rand_user());
    end
    for (int i = 0; i < N_B2B; i++) begin
      issue(RD, addrs[i], '0, '0);
    end
    go_idle();
    drain();

    // counters settle at the edge after the last response
    @(negedge clk_i);
    @(negedge clk_i);
    check_cnt("corr_cnt_o", corr_cnt_o, model_corr);
    check_cnt("uncorr_cnt_o", uncorr_cnt_o, model_uncorr);
    if (((model_corr != '0) || (model_uncorr != '0)) && (last_syndrome_o == '0)) begin
      report_failure("last_syndrome_o is zero after error reads");
    end

    total = err_data + err_user + err_class + err_cnt + err_other;
    $display("errors: data %0d, user %0d, class %0d, counter %0d, other %0d",
             err_data, err_user, err_class, err_cnt, err_other);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    $display("watchdog expired after %0d time units, the run did not complete",
             WATCHDOG_TIME);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- tb.f
hdl/ecc_pkg.sv
hdl/hci_mem_pkg.sv
hdl/secded_39_32_enc.sv
hdl/secded_39_32_dec.sv
hdl/hci_mem_ecc_enc.sv
hdl/hci_mem_bank.sv
hdl/hci_mem_ecc_status.sv
hdl/hci_mem_ecc_top.sv
test/tb_hci_mem_ecc.sv

//--- run_verilator.sh
#!/bin/sh
# build and run the memory path testbench with Verilator
# exits nonzero when the build, the run or the pass search fails

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
  -f tb.f \
  --top-module tb_hci_mem_ecc \
  -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
